/* Makefile */
# Verilator build and run for the register-rename testbench

VERILATOR ?= verilator
TOP       ?= rename_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The log decides the result, a missing pass line fails the target
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "TESTS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/free_list.sv */
module free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    // Allocation side with one register per accepted rename
    input  logic                  alloc,
    output logic                  alloc_ok,
    output rename_pkg::phys_idx_t alloc_idx,

    // Release side for the stale register of a retiring instruction
    input  logic                  release_en,
    input  rename_pkg::phys_idx_t release_idx
);

    rename_pkg::phys_idx_t slots [rename_pkg::free_depth];
    rename_pkg::free_ptr_t rd_ptr;
    rename_pkg::free_ptr_t wr_ptr;
    rename_pkg::free_ptr_t wr_ptr_next;
    rename_pkg::free_cnt_t count;
    rename_pkg::free_cnt_t count_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next-state of the write pointer and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        wr_ptr_next = wr_ptr;
        count_next  = count;
        if (release_en) begin
            wr_ptr_next = wr_ptr + rename_pkg::free_ptr_t'(1);
            count_next  = count_next + rename_pkg::free_cnt_t'(1);
        end
        if (alloc) begin
            count_next = count_next - rename_pkg::free_cnt_t'(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= rename_pkg::free_cnt_t'(rename_pkg::free_depth);
        end else if (flush) begin
            // The whole ring from the write pointer on is the committed free set
            wr_ptr <= wr_ptr_next;
            rd_ptr <= wr_ptr_next;
            count  <= rename_pkg::free_cnt_t'(rename_pkg::free_depth);
        end else begin
            wr_ptr <= wr_ptr_next;
            if (alloc) begin
                rd_ptr <= rd_ptr + rename_pkg::free_ptr_t'(1);
            end
            count <= count_next;
        end
    end

    // Slots from wr_ptr up to rd_ptr still hold in-flight destinations in age order
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::free_depth; i++) begin
                slots[i] <= rename_pkg::phys_idx_t'(rename_pkg::arch_regs + i);
            end
        end else if (release_en) begin
            slots[wr_ptr] <= release_idx;   // Written on flush as well
        end
    end

    assign alloc_ok  = (count != '0);
    assign alloc_idx = slots[rd_ptr];

    // The rename side must never take a register the list does not have
    a_no_alloc_empty: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> (count != '0)
    ) else $error("free_list: alloc with empty list");

    // More releases than the committed free set would mean a lost or doubled register
    a_no_release_full: assert property (
        @(posedge clk) disable iff (rst)
        (release_en && !flush) |->
            (count != rename_pkg::free_cnt_t'(rename_pkg::free_depth))
    ) else $error("free_list: release into full list");

endmodule

/* hw/rename_map.sv */
module rename_map (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,

    // Rename port
    input  rename_pkg::rename_req_t rename_req,
    output logic                    rename_ready,
    output rename_pkg::rename_rsp_t rename_rsp,

    // Free list
    output logic                    alloc,
    input  logic                    alloc_ok,
    input  rename_pkg::phys_idx_t   alloc_idx,

    // Committed table for flush recovery
    input  rename_pkg::map_table_t  committed_next
);

    rename_pkg::map_table_t spec_map;
    logic                   dst_live;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // No accept while the map is being reloaded
    assign rename_ready = alloc_ok && !flush;
    assign alloc        = rename_req.valid && rename_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sources read the table before the destination write lands
    always_comb begin
        rename_rsp.phys_dst  = alloc_idx;
        rename_rsp.phys_src1 = spec_map[rename_req.arch_src1];
        rename_rsp.phys_src2 = spec_map[rename_req.arch_src2];
        rename_rsp.stale_dst = spec_map[rename_req.arch_dst];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_map <= rename_pkg::identity_map();
        end else if (flush) begin
            spec_map <= committed_next;     // Includes a retire in this same cycle
        end else if (alloc) begin
            spec_map[rename_req.arch_dst] <= alloc_idx;
        end
    end

    // A register coming off the free list must not back any architectural register yet
    always_comb begin
        dst_live = 1'b0;
        for (int i = 0; i < rename_pkg::arch_regs; i++) begin
            if (spec_map[i] == alloc_idx) begin
                dst_live = 1'b1;
            end
        end
    end

    a_alloc_not_mapped: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> !dst_live
    ) else $error("rename_map: allocated register %0d is still mapped", alloc_idx);

endmodule

/* hw/rename_pkg.sv */
package rename_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int arch_regs  = 32;
    localparam int phys_regs  = 64;
    localparam int free_depth = phys_regs - arch_regs;  // Registers not held by the committed map

    localparam int arch_w     = $clog2(arch_regs);
    localparam int phys_w     = $clog2(phys_regs);
    localparam int free_ptr_w = $clog2(free_depth);
    localparam int free_cnt_w = free_ptr_w + 1;         // Holds 0 up to free_depth

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Index types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [arch_w-1:0]     arch_idx_t;
    typedef logic [phys_w-1:0]     phys_idx_t;
    typedef logic [free_ptr_w-1:0] free_ptr_t;
    typedef logic [free_cnt_w-1:0] free_cnt_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Requests, responses and tables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic      valid;
        arch_idx_t arch_dst;
        arch_idx_t arch_src1;
        arch_idx_t arch_src2;
    } rename_req_t;

    typedef struct packed {
        phys_idx_t phys_dst;
        phys_idx_t phys_src1;
        phys_idx_t phys_src2;
        phys_idx_t stale_dst;   // Mapping of arch_dst before this rename
    } rename_rsp_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t arch_dst;
        phys_idx_t phys_dst;
    } retire_req_t;

    // Entry i is the physical register holding architectural register i
    typedef phys_idx_t [arch_regs-1:0] map_table_t;

    // Both maps come out of reset as the identity
    function automatic map_table_t identity_map();
        map_table_t m;
        for (int i = 0; i < arch_regs; i++) begin
            m[i] = phys_idx_t'(i);
        end
        return m;
    endfunction

endpackage

/* hw/rename_top.sv */
module rename_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,

    // Rename, one instruction per cycle
    input  rename_pkg::rename_req_t rename_req,
    output logic                    rename_ready,
    output rename_pkg::rename_rsp_t rename_rsp,

    // Retire, one instruction per cycle in program order
    input  rename_pkg::retire_req_t retire_req
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal wires
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                   alloc;
    logic                   alloc_ok;
    rename_pkg::phys_idx_t  alloc_idx;
    logic                   release_en;
    rename_pkg::phys_idx_t  release_idx;
    rename_pkg::map_table_t committed_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instances
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    free_list u_free_list (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc       (alloc),
        .alloc_ok    (alloc_ok),
        .alloc_idx   (alloc_idx),
        .release_en  (release_en),
        .release_idx (release_idx)
    );

    rename_map u_rename_map (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .rename_req     (rename_req),
        .rename_ready   (rename_ready),
        .rename_rsp     (rename_rsp),
        .alloc          (alloc),
        .alloc_ok       (alloc_ok),
        .alloc_idx      (alloc_idx),
        .committed_next (committed_next)
    );

    // Flush needs no port here, the committed state is never speculative
    retire_map u_retire_map (
        .clk            (clk),
        .rst            (rst),
        .retire_req     (retire_req),
        .release_en     (release_en),
        .release_idx    (release_idx),
        .committed_next (committed_next)
    );

endmodule

/* hw/retire_map.sv */
module retire_map (
    input  logic                    clk,
    input  logic                    rst,

    input  rename_pkg::retire_req_t retire_req,

    // Stale register back to the free list
    output logic                    release_en,
    output rename_pkg::phys_idx_t   release_idx,

    // Next committed table, seen by a flush in the same cycle
    output rename_pkg::map_table_t  committed_next
);

    rename_pkg::map_table_t commit_map;
    logic                   dup_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign release_en  = retire_req.valid;
    assign release_idx = commit_map[retire_req.arch_dst];  // Old entry, before the write

    always_comb begin
        committed_next = commit_map;
        if (retire_req.valid) begin
            committed_next[retire_req.arch_dst] = retire_req.phys_dst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_map <= rename_pkg::identity_map();
        end else begin
            commit_map <= committed_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Does the retiring register already back some other architectural register
    always_comb begin
        dup_hit = 1'b0;
        for (int i = 0; i < rename_pkg::arch_regs; i++) begin
            if ((rename_pkg::arch_idx_t'(i) != retire_req.arch_dst) &&
                (commit_map[i] == retire_req.phys_dst)) begin
                dup_hit = 1'b1;
            end
        end
    end

    // A physical register is owned by at most one committed mapping
    a_retire_unique: assert property (
        @(posedge clk) disable iff (rst)
        retire_req.valid |-> !dup_hit
    ) else $error("retire_map: phys_dst %0d already committed elsewhere",
                  retire_req.phys_dst);

endmodule

/* list.f */
hw/rename_pkg.sv
hw/free_list.sv
hw/rename_map.sv
hw/retire_map.sv
hw/rename_top.sv
sim/rename_tb.sv

/* sim/rename_tb.sv */
module rename_tb;

    localparam int reset_cycles    = 10;
    localparam int directed_cycles = 300;   // Upper bound on the directed part including stalls
    localparam int random_cycles   = 2000;
    localparam int watchdog_cycles = reset_cycles + directed_cycles + random_cycles + 100;

    logic                    clk;
    logic                    rst;
    logic                    flush;
    rename_pkg::rename_req_t rename_req;
    logic                    rename_ready;
    rename_pkg::rename_rsp_t rename_rsp;
    rename_pkg::retire_req_t retire_req;

    integer seed = 32'h6e48_3d7b;

    // Reference model state
    rename_pkg::phys_idx_t   spec_map   [rename_pkg::arch_regs];
    rename_pkg::phys_idx_t   commit_map [rename_pkg::arch_regs];
    rename_pkg::phys_idx_t   free_q     [$];
    rename_pkg::phys_idx_t   hist_q     [$];   // Free set as of the last retire
    rename_pkg::retire_req_t inflight_q [$];   // Renamed and not yet retired in age order
    logic                    accepted = 1'b0;

    rename_top u_rename_top (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .rename_req   (rename_req),
        .rename_ready (rename_ready),
        .rename_rsp   (rename_rsp),
        .retire_req   (retire_req)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic void init_model();
        free_q.delete();
        hist_q.delete();
        inflight_q.delete();
        for (int i = 0; i < rename_pkg::arch_regs; i++) begin
            spec_map[i]   = rename_pkg::phys_idx_t'(i);
            commit_map[i] = rename_pkg::phys_idx_t'(i);
        end
        for (int i = 0; i < rename_pkg::free_depth; i++) begin
            free_q.push_back(rename_pkg::phys_idx_t'(rename_pkg::arch_regs + i));
            hist_q.push_back(rename_pkg::phys_idx_t'(rename_pkg::arch_regs + i));
        end
    endfunction

    function automatic logic expect_ready();
        return (free_q.size() != 0) && !flush;
    endfunction

    // Sources and stale come from the map as it stands before this rename
    function automatic rename_pkg::rename_rsp_t expect_rename(rename_pkg::rename_req_t req);
        rename_pkg::rename_rsp_t rsp;
        rsp.phys_dst  = free_q[0];
        rsp.phys_src1 = spec_map[req.arch_src1];
        rsp.phys_src2 = spec_map[req.arch_src2];
        rsp.stale_dst = spec_map[req.arch_dst];
        return rsp;
    endfunction

    function automatic void model_rename(rename_pkg::rename_req_t req);
        rename_pkg::retire_req_t ent;
        ent.valid    = 1'b1;
        ent.arch_dst = req.arch_dst;
        ent.phys_dst = free_q.pop_front();
        spec_map[req.arch_dst] = ent.phys_dst;
        inflight_q.push_back(ent);
    endfunction

    function automatic void model_retire(rename_pkg::retire_req_t ret);
        rename_pkg::phys_idx_t stale;
        stale = commit_map[ret.arch_dst];
        commit_map[ret.arch_dst] = ret.phys_dst;
        free_q.push_back(stale);
        hist_q.push_back(stale);
        hist_q.delete(0);
        inflight_q.delete(0);
    endfunction

    function automatic void model_flush();
        spec_map = commit_map;
        free_q   = hist_q;
        inflight_q.delete();   // Everything still speculative is gone
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_run(input string why);
        $display("TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, exp, got);
            stop_run("DUT output differs from the reference model");
        end
    endtask

    // Outputs are settled at the falling edge and the model then steps over the next rising edge
    always @(negedge clk) begin : compare
        rename_pkg::rename_rsp_t exp_rsp;
        if (rst) begin
            accepted = 1'b0;
        end else begin
            check_value("rename_ready", 32'(expect_ready()), 32'(rename_ready));
            accepted = rename_req.valid && rename_ready;
            if (accepted) begin
                exp_rsp = expect_rename(rename_req);
                check_value("rename_rsp.phys_dst", 32'(exp_rsp.phys_dst),
                            32'(rename_rsp.phys_dst));
                check_value("rename_rsp.phys_src1", 32'(exp_rsp.phys_src1),
                            32'(rename_rsp.phys_src1));
                check_value("rename_rsp.phys_src2", 32'(exp_rsp.phys_src2),
                            32'(rename_rsp.phys_src2));
                check_value("rename_rsp.stale_dst", 32'(exp_rsp.stale_dst),
                            32'(rename_rsp.stale_dst));
                model_rename(rename_req);
            end
            if (retire_req.valid) begin
                model_retire(retire_req);
            end
            if (flush) begin
                model_flush();
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic rename_pkg::rename_req_t make_req(input int d, input int s1, input int s2);
        rename_pkg::rename_req_t rq;
        rq.valid     = 1'b1;
        rq.arch_dst  = rename_pkg::arch_idx_t'(d);
        rq.arch_src1 = rename_pkg::arch_idx_t'(s1);
        rq.arch_src2 = rename_pkg::arch_idx_t'(s2);
        return rq;
    endfunction

    // Retire always takes the oldest renamed instruction
    task automatic apply_inputs(input rename_pkg::rename_req_t rq, input logic do_retire,
                                input logic fl);
        rename_req <= rq;
        retire_req <= '0;
        if (do_retire && (inflight_q.size() != 0)) begin
            retire_req <= inflight_q[0];
        end
        flush <= fl;
    endtask

    task automatic drive(input rename_pkg::rename_req_t rq, input logic do_retire,
                         input logic fl);
        @(posedge clk);
        apply_inputs(rq, do_retire, fl);
    endtask

    // Holds the request until the DUT shows ready so it is taken at the next rising edge
    task automatic rename_one(input rename_pkg::rename_req_t rq, input logic do_retire);
        drive(rq, do_retire, 1'b0);
        @(negedge clk);
        while (!rename_ready) begin
            drive(rq, 1'b0, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic idle(input int n, input logic do_retire);
        repeat (n) drive('0, do_retire, 1'b0);
    endtask

    initial begin : main
        rename_pkg::rename_req_t held;
        rename_pkg::rename_req_t cur;
        logic                    do_ret;
        logic                    do_fl;
        rst        = 1'b1;
        flush      = 1'b0;
        rename_req = '0;
        retire_req = '0;
        init_model();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Fresh registers come in order and a same-register source gets the old mapping
        rename_one(make_req(1, 1, 2), 1'b0);
        rename_one(make_req(2, 1, 3), 1'b0);
        rename_one(make_req(1, 1, 2), 1'b0);
        rename_one(make_req(3, 2, 1), 1'b0);
        for (int i = 4; i < 32; i++) begin
            rename_one(make_req(i, i - 1, 31), 1'b0);
        end

        // The free list runs dry and the request waits until one retire frees a register
        held = make_req(5, 4, 3);
        drive(held, 1'b0, 1'b0);
        repeat (3) begin
            @(negedge clk);
            check_value("rename_ready", 32'(0), 32'(rename_ready));
            drive(held, 1'b0, 1'b0);
        end
        rename_one(held, 1'b1);

        // Released registers queue behind the ones already free
        idle(8, 1'b1);
        for (int i = 0; i < 6; i++) begin
            rename_one(make_req(i + 10, i, i + 20), 1'b1);
        end

        // Flush together with a retire and then read every register once
        drive('0, 1'b1, 1'b1);
        for (int i = 0; i < 16; i++) begin
            rename_one(make_req(i, 2 * i, 2 * i + 1), 1'b0);
        end
        idle(3, 1'b1);
        drive('0, 1'b0, 1'b1);
        for (int i = 0; i < 8; i++) begin
            rename_one(make_req(31 - i, i, 31 - i), 1'b1);
        end

        // In the random mix an unaccepted request is held as it was
        cur = '0;
        repeat (random_cycles) begin
            @(posedge clk);
            if (!cur.valid || accepted) begin
                cur = '0;
                if (($unsigned($random(seed)) % 100) < 70) begin
                    cur = make_req($unsigned($random(seed)) % 32,
                                   $unsigned($random(seed)) % 32,
                                   $unsigned($random(seed)) % 32);
                end
            end
            do_ret = ($unsigned($random(seed)) % 100) < 45;
            do_fl  = ($unsigned($random(seed)) % 100) < 2;
            apply_inputs(cur, do_ret, do_fl);
        end

        idle(2, 1'b0);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        stop_run("Watchdog expired before the tests finished");
    end

endmodule
